// File: hw/flash_ctrl_top.sv
`timescale 1ns/1ps

module flash_ctrl_top (
   input  logic                   clk,
   input  logic                   reset,
   // program command port
   input  logic                   prog_req,
   input  flash_pkg::flash_addr_t prog_addr,
   input  flash_pkg::word_count_t prog_count,
   output logic                   prog_ack,
   // write data port
   output logic                   wr_req,
   input  logic                   wr_ack,
   input  flash_pkg::flash_word_t wr_data,
   // read command port
   input  logic                   rd_cmd_req,
   input  flash_pkg::flash_addr_t rd_addr,
   input  flash_pkg::word_count_t rd_count,
   output logic                   rd_cmd_ack,
   // read data port
   output logic                   rd_data_req,
   output flash_pkg::flash_word_t rd_data,
   input  logic                   rd_data_ack,
   // SPI pins
   output logic                   spi_sck,
   output logic                   spi_ss,
   output logic                   spi_mosi,
   input  logic                   spi_miso
);
   import flash_pkg::*;

   logic      pg_bus_req;
   spi_req_t  pg_bus_cmd;
   logic      pg_bus_ack;
   logic      rd_bus_req;
   spi_req_t  rd_bus_cmd;
   logic      rd_bus_ack;
   logic      eng_req;
   spi_req_t  eng_cmd;
   logic      eng_ack;
   spi_byte_t eng_rx_byte;   // shared by both clients

   page_programmer page_programmer_i (
      .clk       (clk),
      .reset     (reset),
      .cmd_req   (prog_req),
      .cmd_addr  (prog_addr),
      .cmd_count (prog_count),
      .cmd_ack   (prog_ack),
      .wr_req    (wr_req),
      .wr_ack    (wr_ack),
      .wr_data   (wr_data),
      .bus_req   (pg_bus_req),
      .bus_cmd   (pg_bus_cmd),
      .bus_ack   (pg_bus_ack)
   );

   page_reader page_reader_i (
      .clk       (clk),
      .reset     (reset),
      .cmd_req   (rd_cmd_req),
      .cmd_addr  (rd_addr),
      .cmd_count (rd_count),
      .cmd_ack   (rd_cmd_ack),
      .data_req  (rd_data_req),
      .data      (rd_data),
      .data_ack  (rd_data_ack),
      .bus_req   (rd_bus_req),
      .bus_cmd   (rd_bus_cmd),
      .bus_ack   (rd_bus_ack),
      .rx_byte   (eng_rx_byte)
   );

   spi_bus_arbiter spi_bus_arbiter_i (
      .clk      (clk),
      .reset    (reset),
      .prog_req (pg_bus_req),
      .prog_cmd (pg_bus_cmd),
      .prog_ack (pg_bus_ack),
      .read_req (rd_bus_req),
      .read_cmd (rd_bus_cmd),
      .read_ack (rd_bus_ack),
      .eng_req  (eng_req),
      .eng_cmd  (eng_cmd),
      .eng_ack  (eng_ack)
   );

   spi_byte_engine spi_byte_engine_i (
      .clk      (clk),
      .reset    (reset),
      .req      (eng_req),
      .cmd      (eng_cmd),
      .ack      (eng_ack),
      .rx_byte  (eng_rx_byte),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

endmodule

// File: hw/flash_pkg.sv
package flash_pkg;

   // bus and data widths
   localparam int ADDR_W  = 24;
   localparam int WORD_W  = 16;
   localparam int BYTE_W  = 8;
   localparam int COUNT_W = 8;

   // SCK is clk / SCK_PHASES, rising edge in the middle of the bit
   localparam int SCK_PHASES     = 8;
   localparam int SCK_HIGH_PHASE = 4;

   typedef logic [ADDR_W-1:0]  flash_addr_t;   // byte address in the flash
   typedef logic [WORD_W-1:0]  flash_word_t;   // data word, high byte goes first
   typedef logic [BYTE_W-1:0]  spi_byte_t;
   typedef logic [COUNT_W-1:0] word_count_t;   // 1..128 words, 0 never used

   // serial flash opcodes
   localparam spi_byte_t CMD_WREN    = 8'h06;
   localparam spi_byte_t CMD_PROGRAM = 8'h02;
   localparam spi_byte_t CMD_READ    = 8'h03;

   // filler clocked out while the flash returns read data
   localparam spi_byte_t DUMMY_BYTE = 8'h00;

   // one byte request from a client to the byte engine
   typedef struct packed {
      spi_byte_t tx_byte;
      logic      last;      // chip select goes high after this byte
   } spi_req_t;

   // arbiter grant and round-robin pointer
   typedef enum logic {
      CLIENT_PROG,
      CLIENT_READ
   } client_id_t;

endpackage

// File: hw/page_programmer.sv
`timescale 1ns/1ps

module page_programmer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_req,
   input  flash_pkg::flash_addr_t cmd_addr,
   input  flash_pkg::word_count_t cmd_count,
   output logic                   cmd_ack,
   output logic                   wr_req,
   input  logic                   wr_ack,
   input  flash_pkg::flash_word_t wr_data,
   output logic                   bus_req,
   output flash_pkg::spi_req_t    bus_cmd,
   input  logic                   bus_ack
);
   import flash_pkg::*;

   typedef enum logic [2:0] {
      PG_IDLE,
      PG_WREN,
      PG_CMD,
      PG_ADDR,
      PG_FETCH,
      PG_HI,
      PG_LO,
      PG_DONE
   } pg_state_t;

   pg_state_t   state;
   flash_addr_t addr_sr;     // address bytes leave from the top
   logic [1:0]  addr_idx;
   word_count_t words_left;
   flash_word_t word_buf;
   spi_req_t    tx;
   logic        tx_en;
   logic        tx_done;

   assign tx_done = bus_req && bus_ack;

   // byte to send in the current state
   always_comb begin
      tx_en      = 1'b1;
      tx.tx_byte = DUMMY_BYTE;
      tx.last    = 1'b0;
      case (state)
         PG_WREN: begin
            tx.tx_byte = CMD_WREN;
            tx.last    = 1'b1;   // WREN is a frame of its own
         end
         PG_CMD:  tx.tx_byte = CMD_PROGRAM;
         PG_ADDR: tx.tx_byte = addr_sr[ADDR_W-1 -: BYTE_W];
         PG_HI:   tx.tx_byte = word_buf[WORD_W-1 -: BYTE_W];
         PG_LO: begin
            tx.tx_byte = word_buf[BYTE_W-1:0];
            tx.last    = (words_left == 8'd1);
         end
         default: tx_en = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= PG_IDLE;
         cmd_ack  <= 1'b0;
         wr_req   <= 1'b0;
         bus_req  <= 1'b0;
         addr_idx <= '0;
      end else begin
         // one byte per state, new req only once the old ack is gone
         if (tx_en && !bus_req && !bus_ack) begin
            bus_req <= 1'b1;
            bus_cmd <= tx;
         end else if (tx_done) begin
            bus_req <= 1'b0;
         end

         case (state)
            PG_IDLE: begin
               if (cmd_req) begin
                  addr_sr    <= cmd_addr;
                  words_left <= cmd_count;
                  addr_idx   <= '0;
                  state      <= PG_WREN;
               end
            end
            PG_WREN: if (tx_done) state <= PG_CMD;
            PG_CMD:  if (tx_done) state <= PG_ADDR;
            PG_ADDR: begin
               if (tx_done) begin
                  addr_sr  <= {addr_sr[ADDR_W-BYTE_W-1:0], DUMMY_BYTE};
                  addr_idx <= addr_idx + 2'd1;
                  if (addr_idx == 2'd2) begin
                     state <= PG_FETCH;
                  end
               end
            end
            PG_FETCH: begin
               if (!wr_req && !wr_ack) begin
                  wr_req <= 1'b1;
               end else if (wr_req && wr_ack) begin
                  word_buf <= wr_data;
                  wr_req   <= 1'b0;
                  state    <= PG_HI;
               end
            end
            PG_HI: if (tx_done) state <= PG_LO;
            PG_LO: begin
               if (tx_done) begin
                  if (words_left == 8'd1) begin
                     state <= PG_DONE;
                  end else begin
                     words_left <= words_left - 8'd1;
                     state      <= PG_FETCH;
                  end
               end
            end
            PG_DONE: begin
               cmd_ack <= 1'b1;
               if (cmd_ack && !cmd_req) begin
                  cmd_ack <= 1'b0;
                  state   <= PG_IDLE;
               end
            end
            default: state <= PG_IDLE;
         endcase
      end
   end

endmodule

// File: hw/page_reader.sv
`timescale 1ns/1ps

module page_reader (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_req,
   input  flash_pkg::flash_addr_t cmd_addr,
   input  flash_pkg::word_count_t cmd_count,
   output logic                   cmd_ack,
   output logic                   data_req,
   output flash_pkg::flash_word_t data,
   input  logic                   data_ack,
   output logic                   bus_req,
   output flash_pkg::spi_req_t    bus_cmd,
   input  logic                   bus_ack,
   input  flash_pkg::spi_byte_t   rx_byte
);
   import flash_pkg::*;

   typedef enum logic [2:0] {
      RD_IDLE,
      RD_CMD,
      RD_ADDR,
      RD_HI,
      RD_LO,
      RD_OFFER,
      RD_DONE
   } rd_state_t;

   rd_state_t   state;
   flash_addr_t addr_sr;
   logic [1:0]  addr_idx;
   word_count_t words_left;
   spi_req_t    tx;
   logic        tx_en;
   logic        tx_done;

   assign tx_done = bus_req && bus_ack;

   always_comb begin
      tx_en      = 1'b1;
      tx.tx_byte = DUMMY_BYTE;   // clocks the read data in
      tx.last    = 1'b0;
      case (state)
         RD_CMD:  tx.tx_byte = CMD_READ;
         RD_ADDR: tx.tx_byte = addr_sr[ADDR_W-1 -: BYTE_W];
         RD_HI:   tx.last    = 1'b0;
         RD_LO:   tx.last    = (words_left == 8'd1);
         default: tx_en      = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= RD_IDLE;
         cmd_ack  <= 1'b0;
         data_req <= 1'b0;
         bus_req  <= 1'b0;
         addr_idx <= '0;
      end else begin
         if (tx_en && !bus_req && !bus_ack) begin
            bus_req <= 1'b1;
            bus_cmd <= tx;
         end else if (tx_done) begin
            bus_req <= 1'b0;
         end

         case (state)
            RD_IDLE: begin
               if (cmd_req) begin
                  addr_sr    <= cmd_addr;
                  words_left <= cmd_count;
                  addr_idx   <= '0;
                  state      <= RD_CMD;
               end
            end
            RD_CMD: if (tx_done) state <= RD_ADDR;
            RD_ADDR: begin
               if (tx_done) begin
                  addr_sr  <= {addr_sr[ADDR_W-BYTE_W-1:0], DUMMY_BYTE};
                  addr_idx <= addr_idx + 2'd1;
                  if (addr_idx == 2'd2) begin
                     state <= RD_HI;
                  end
               end
            end
            RD_HI: begin
               if (tx_done) begin
                  data[WORD_W-1 -: BYTE_W] <= rx_byte;
                  state <= RD_LO;
               end
            end
            RD_LO: begin
               if (tx_done) begin
                  data[BYTE_W-1:0] <= rx_byte;
                  state <= RD_OFFER;
               end
            end
            RD_OFFER: begin
               // frame stays open here with SCK parked low
               if (!data_req && !data_ack) begin
                  data_req <= 1'b1;
               end else if (data_req && data_ack) begin
                  data_req <= 1'b0;
                  if (words_left == 8'd1) begin
                     state <= RD_DONE;
                  end else begin
                     words_left <= words_left - 8'd1;
                     state      <= RD_HI;
                  end
               end
            end
            RD_DONE: begin
               cmd_ack <= 1'b1;
               if (cmd_ack && !cmd_req) begin
                  cmd_ack <= 1'b0;
                  state   <= RD_IDLE;
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

endmodule

// File: hw/spi_bus_arbiter.sv
`timescale 1ns/1ps

module spi_bus_arbiter (
   input  logic                clk,
   input  logic                reset,
   input  logic                prog_req,
   input  flash_pkg::spi_req_t prog_cmd,
   output logic                prog_ack,
   input  logic                read_req,
   input  flash_pkg::spi_req_t read_cmd,
   output logic                read_ack,
   output logic                eng_req,
   output flash_pkg::spi_req_t eng_cmd,
   input  logic                eng_ack
);
   import flash_pkg::*;

   client_id_t grant;
   client_id_t rr_ptr;        // client that wins a tie
   client_id_t gnt_next;
   logic       locked;        // a frame owns the engine
   logic       end_pending;   // byte marked last has been forwarded
   logic       eng_ack_d;
   logic       fwd_req;
   spi_req_t   fwd_cmd;

   // grant only moves while no frame is open
   always_comb begin
      gnt_next = grant;
      if (!locked) begin
         if (prog_req && read_req) begin
            gnt_next = rr_ptr;
         end else if (read_req) begin
            gnt_next = CLIENT_READ;
         end else begin
            gnt_next = CLIENT_PROG;
         end
      end
      fwd_req = (gnt_next == CLIENT_PROG) ? prog_req : read_req;
      fwd_cmd = (gnt_next == CLIENT_PROG) ? prog_cmd : read_cmd;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         grant       <= CLIENT_PROG;
         rr_ptr      <= CLIENT_PROG;
         locked      <= 1'b0;
         end_pending <= 1'b0;
         eng_ack_d   <= 1'b0;
         eng_req     <= 1'b0;
         prog_ack    <= 1'b0;
         read_ack    <= 1'b0;
      end else begin
         grant     <= gnt_next;
         eng_req   <= fwd_req;
         eng_ack_d <= eng_ack;
         prog_ack  <= locked && (grant == CLIENT_PROG) && eng_ack;
         read_ack  <= locked && (grant == CLIENT_READ) && eng_ack;
         if (fwd_req) begin
            locked <= 1'b1;
         end
         if (fwd_req && fwd_cmd.last) begin
            end_pending <= 1'b1;
         end
         // frame is over once the last byte's ack has dropped
         if (end_pending && eng_ack_d && !eng_ack) begin
            locked      <= 1'b0;
            end_pending <= 1'b0;
            rr_ptr      <= (grant == CLIENT_PROG) ? CLIENT_READ : CLIENT_PROG;
         end
      end
   end

   always_ff @(posedge clk) begin
      eng_cmd <= fwd_cmd;   // travels with eng_req
   end

endmodule

// File: hw/spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  flash_pkg::spi_req_t  cmd,
   output logic                 ack,
   output flash_pkg::spi_byte_t rx_byte,
   output logic                 spi_sck,
   output logic                 spi_ss,
   output logic                 spi_mosi,
   input  logic                 spi_miso
);
   import flash_pkg::*;

   typedef enum logic [1:0] {
      ENG_IDLE,
      ENG_SHIFT,
      ENG_DONE
   } eng_state_t;

   eng_state_t state;
   logic [2:0] phase;       // clk cycle inside the current bit
   logic [2:0] bit_cnt;
   spi_byte_t  tx_shift;
   logic       last_byte;

   // mode 0, MSB first
   // MOSI moves at phase 0 while SCK is low, MISO is taken on the rising edge
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= ENG_IDLE;
         phase    <= '0;
         bit_cnt  <= '0;
         ack      <= 1'b0;
         spi_sck  <= 1'b0;
         spi_ss   <= 1'b1;
         spi_mosi <= 1'b0;
      end else begin
         case (state)
            ENG_IDLE: begin
               if (req) begin
                  tx_shift  <= cmd.tx_byte;
                  last_byte <= cmd.last;
                  spi_ss    <= 1'b0;   // already low inside a frame
                  phase     <= '0;
                  bit_cnt   <= '0;
                  state     <= ENG_SHIFT;
               end
            end
            ENG_SHIFT: begin
               phase <= phase + 3'd1;
               if (phase == '0) begin
                  spi_sck  <= 1'b0;
                  spi_mosi <= tx_shift[BYTE_W-1];
               end
               if (phase == 3'(SCK_HIGH_PHASE)) begin
                  spi_sck <= 1'b1;
                  rx_byte <= {rx_byte[BYTE_W-2:0], spi_miso};
               end
               if (phase == 3'(SCK_PHASES - 1)) begin
                  tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
                  bit_cnt  <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     spi_sck <= 1'b0;   // park SCK low between bytes
                     ack     <= 1'b1;
                     state   <= ENG_DONE;
                  end
               end
            end
            ENG_DONE: begin
               if (last_byte) begin
                  spi_ss <= 1'b1;      // end of frame
               end
               if (!req) begin
                  ack   <= 1'b0;
                  state <= ENG_IDLE;
               end
            end
            default: state <= ENG_IDLE;
         endcase
      end
   end

endmodule

// File: run_sim.sh
#!/bin/bash
# build and run the flash controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module tb_flash_ctrl -o tb_flash_ctrl
if [ $? -ne 0 ]; then
   echo "verilator compile step failed"
   exit 1
fi

./obj_dir/tb_flash_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench passed" sim.log; then
   exit 0
fi
exit 1

// File: src.f
hw/flash_pkg.sv
hw/spi_byte_engine.sv
hw/spi_bus_arbiter.sv
hw/page_programmer.sv
hw/page_reader.sv
hw/flash_ctrl_top.sv
tests/spi_flash_model.sv
tests/tb_flash_ctrl.sv

// File: tests/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
   input  logic spi_sck,
   input  logic spi_ss,
   input  logic spi_mosi,
   output logic spi_miso
);
   import flash_pkg::*;

   localparam int MEM_SIZE   = 4096;   // only the low 12 address bits are decoded
   localparam int MAX_FRAMES = 256;

   logic [7:0]  mem [0:MEM_SIZE-1];
   spi_byte_t   frame_cmd [0:MAX_FRAMES-1];   // opcode of each finished frame
   int          frame_len [0:MAX_FRAMES-1];   // bytes seen in each finished frame
   int          frame_count;
   int          bit_cnt;
   int          byte_cnt;
   spi_byte_t   in_sr;
   spi_byte_t   out_sr;
   spi_byte_t   cmd;
   flash_addr_t addr;
   logic        wel;    // write enable latch
   logic        ss_q;
   logic        sck_q;

   initial begin
      for (int i = 0; i < MEM_SIZE; i++) begin
         mem[i] = 8'hFF;   // erased
      end
      frame_count = 0;
      bit_cnt     = 0;
      byte_cnt    = 0;
      in_sr       = '0;
      out_sr      = '0;
      cmd         = '0;
      addr        = '0;
      wel         = 1'b0;
      ss_q        = 1'b1;
      sck_q       = 1'b0;
      spi_miso    = 1'b0;
   end

   always @(spi_sck or spi_ss) begin
      if (spi_ss === 1'b0 && ss_q !== 1'b0) begin   // frame start
         bit_cnt  = 0;
         byte_cnt = 0;
         out_sr   = '0;
         spi_miso = 1'b0;
      end
      if (spi_ss === 1'b1 && ss_q === 1'b0 && byte_cnt > 0) begin   // frame end
         if (frame_count < MAX_FRAMES) begin
            frame_cmd[frame_count] = cmd;
            frame_len[frame_count] = byte_cnt;
         end
         frame_count = frame_count + 1;
         if (cmd == CMD_WREN) wel = 1'b1;
         if (cmd == CMD_PROGRAM) wel = 1'b0;
      end
      if (spi_ss === 1'b0 && spi_sck === 1'b1 && sck_q === 1'b0) begin
         in_sr   = {in_sr[6:0], spi_mosi};   // mode 0, sample on rise
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            bit_cnt = 0;
            if (byte_cnt == 0) begin
               cmd = in_sr;
            end else if (byte_cnt <= 3) begin
               addr = {addr[15:0], in_sr};
            end else if (cmd == CMD_PROGRAM && wel) begin
               // wraps inside the 256 byte page
               mem[{addr[11:8], 8'(addr[7:0] + 8'(byte_cnt - 4))}] = in_sr;
            end
            byte_cnt = byte_cnt + 1;
            if (cmd == CMD_READ && byte_cnt >= 4) begin
               out_sr = mem[12'(addr + flash_addr_t'(byte_cnt - 4))];
            end
         end
      end
      if (spi_ss === 1'b0 && spi_sck === 1'b0 && sck_q === 1'b1) begin
         spi_miso = out_sr[7];   // next bit goes out on the fall
         out_sr   = {out_sr[6:0], 1'b0};
      end
      ss_q  = spi_ss;
      sck_q = spi_sck;
   end

endmodule

// File: tests/tb_flash_ctrl.sv
`timescale 1ns/1ps

module tb_flash_ctrl;
   import flash_pkg::*;

   localparam int MEM_SIZE      = 4096;
   localparam int T2_MAX_WORDS  = 64;
   localparam int T3_RUNS       = 20;
   localparam int T3_MAX_WORDS  = 16;
   localparam int T4_PROG_WORDS = 16;
   localparam int T4_READ_WORDS = 8;
   // a program sends WREN + opcode + address + data
   // a read sends opcode + address + data
   localparam int TOTAL_BYTES = (5 + 2 * T2_MAX_WORDS) + (4 + 2 * T2_MAX_WORDS)
      + T3_RUNS * ((5 + 2 * T3_MAX_WORDS) + (4 + 2 * T3_MAX_WORDS))
      + (5 + 2 * T4_PROG_WORDS) + (4 + 2 * T4_READ_WORDS);
   localparam int CYCLE_LIMIT = TOTAL_BYTES * 70 * 2;

   logic        clk;
   logic        reset;
   logic        prog_req;
   flash_addr_t prog_addr;
   word_count_t prog_count;
   logic        prog_ack;
   logic        wr_req;
   logic        wr_ack;
   flash_word_t wr_data;
   logic        rd_cmd_req;
   flash_addr_t rd_addr;
   word_count_t rd_count;
   logic        rd_cmd_ack;
   logic        rd_data_req;
   flash_word_t rd_data;
   logic        rd_data_ack;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;

   integer      seed;
   int          errors;
   int          checks;
   int          tests;
   int          cycles;
   int          progs;
   int          reads;
   int          ss_violations;
   logic [7:0]  ref_mem [0:MEM_SIZE-1];
   flash_word_t wr_queue[$];
   flash_word_t rd_queue[$];

   flash_ctrl_top flash_ctrl_top_i (.*);

   spi_flash_model flash_model_i (
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic int unsigned rand_below(int unsigned n);
      int unsigned r;
      r = $unsigned($random(seed));
      return r % n;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;   // drive and sample away from the edge
   endtask

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic end_test(string name, int err_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
   endtask

   task automatic write_ref(flash_addr_t addr, int offset, logic [7:0] b);
      ref_mem[{addr[11:8], 8'(addr[7:0] + 8'(offset))}] = b;
   endtask

   function automatic flash_word_t ref_word(flash_addr_t addr, int i);
      logic [11:0] a;
      a = 12'(addr + flash_addr_t'(2 * i));
      return {ref_mem[a], ref_mem[a + 12'd1]};
   endfunction

   task automatic do_program(flash_addr_t addr, int count);
      flash_word_t w;
      for (int i = 0; i < count; i++) begin
         w = flash_word_t'(rand_below(65536));
         wr_queue.push_back(w);
         write_ref(addr, 2 * i, w[15:8]);
         write_ref(addr, 2 * i + 1, w[7:0]);
      end
      prog_addr  = addr;
      prog_count = word_count_t'(count);
      prog_req   = 1'b1;
      do step(); while (!prog_ack);
      prog_req = 1'b0;
      do step(); while (prog_ack);
      progs++;
   endtask

   task automatic do_read(flash_addr_t addr, int count);
      rd_queue.delete();
      rd_addr    = addr;
      rd_count   = word_count_t'(count);
      rd_cmd_req = 1'b1;
      do step(); while (!rd_cmd_ack);
      rd_cmd_req = 1'b0;
      do step(); while (rd_cmd_ack);
      check_value("rd_word_count", rd_queue.size(), count);
      for (int i = 0; i < count && rd_queue.size() > 0; i++) begin
         check_value("rd_data", rd_queue.pop_front(), ref_word(addr, i));
      end
      reads++;
   endtask

   // write data port answered after a random delay
   initial begin
      wr_ack  = 1'b0;
      wr_data = '0;
      forever begin
         step();
         if (wr_req && !wr_ack) begin
            repeat (rand_below(4)) step();
            if (wr_queue.size() == 0) begin
               errors++;
               $display("write data was requested with no word left to send");
               wr_data = '0;
            end else begin
               wr_data = wr_queue.pop_front();
            end
            wr_ack = 1'b1;
            do step(); while (wr_req);
            wr_ack = 1'b0;
         end
      end
   end

   // read data port with random back-pressure too
   initial begin
      rd_data_ack = 1'b0;
      forever begin
         step();
         if (rd_data_req && !rd_data_ack) begin
            repeat (rand_below(4)) step();
            rd_queue.push_back(rd_data);
            rd_data_ack = 1'b1;
            do step(); while (rd_data_req);
            rd_data_ack = 1'b0;
         end
      end
   end

   initial begin   // chip select must be high while both command ports rest
      ss_violations = 0;
      forever begin
         step();
         if (!reset && !prog_req && !prog_ack && !rd_cmd_req && !rd_cmd_ack
             && spi_ss !== 1'b1) begin
            if (ss_violations == 0) begin
               $display("chip select was low while both command ports were idle");
            end
            ss_violations++;
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      int          err0;
      int          n;
      int          frame0;
      int          w_idx;
      int          p_idx;
      int          r_idx;
      flash_addr_t a;
      spi_byte_t   c;
      seed       = 83;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      progs      = 0;
      reads      = 0;
      reset      = 1'b1;
      prog_req   = 1'b0;
      prog_addr  = '0;
      prog_count = '0;
      rd_cmd_req = 1'b0;
      rd_addr    = '0;
      rd_count   = '0;
      for (int i = 0; i < MEM_SIZE; i++) begin
         ref_mem[i] = 8'hFF;
      end
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      step();
      step();

      err0 = errors;
      check_value("spi_ss", spi_ss, 1);
      check_value("spi_sck", spi_sck, 0);
      check_value("prog_ack", prog_ack, 0);
      check_value("wr_req", wr_req, 0);
      check_value("rd_cmd_ack", rd_cmd_ack, 0);
      check_value("rd_data_req", rd_data_req, 0);
      end_test("reset state", err0);

      err0 = errors;
      a = flash_addr_t'(rand_below(12)) << 8;   // page aligned and below 0xC00
      n = 1 + int'(rand_below(T2_MAX_WORDS));
      do_program(a, n);
      do_read(a, n);
      end_test("program then read back", err0);

      err0 = errors;
      for (int k = 0; k < T3_RUNS; k++) begin
         a = flash_addr_t'(rand_below(3072));   // may cross a page end
         n = 1 + int'(rand_below(T3_MAX_WORDS));
         if (k == 0) begin
            a[7:0] = 8'hF9;   // first run always wraps inside its page
            n      = T3_MAX_WORDS;
         end
         do_program(a, n);
         do_read(a, n);
      end
      end_test("random programs with page wrap", err0);

      // pages 0xC00 and 0xE00 are never programmed before this point
      err0   = errors;
      frame0 = flash_model_i.frame_count;
      fork
         do_program(24'h000C00, T4_PROG_WORDS);
         do_read(24'h000E00, T4_READ_WORDS);
      join
      check_value("frames_in_contention", flash_model_i.frame_count - frame0, 3);
      w_idx = -1;
      p_idx = -1;
      r_idx = -1;
      for (int k = frame0; k < frame0 + 3; k++) begin
         c = flash_model_i.frame_cmd[k];
         if (c == CMD_WREN) begin
            w_idx = k;
            check_value("wren_frame_len", flash_model_i.frame_len[k], 1);
         end else if (c == CMD_PROGRAM) begin
            p_idx = k;
            check_value("program_frame_len", flash_model_i.frame_len[k], 4 + 2 * T4_PROG_WORDS);
         end else if (c == CMD_READ) begin
            r_idx = k;
            check_value("read_frame_len", flash_model_i.frame_len[k], 4 + 2 * T4_READ_WORDS);
         end else begin
            errors++;
            $display("frame %0d carried an unexpected opcode 0x%0h", k, c);
         end
      end
      if (w_idx < 0 || p_idx < 0 || r_idx < 0 || w_idx > p_idx) begin
         errors++;
         $display("contention frames were missing or out of order");
      end
      end_test("program and read in the same cycle", err0);

      err0 = errors;
      check_value("frame_count", flash_model_i.frame_count, 2 * progs + reads);
      check_value("ss_idle_violations", ss_violations, 0);
      check_value("spi_ss", spi_ss, 1);
      end_test("frame accounting", err0);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
